/* dv/tb_core_peri_group.sv */
// Random-stimulus testbench of the core peripheral group with a fixed seed
// The external slot is modeled here as a 16-word memory with 0 to 3 wait cycles
`timescale 1ns/1ns

module tb_core_peri_group
	import core_peri_pkg::*, timer_reg_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_XFER = 200;
	localparam int XFER_CYCLES = 20;

	logic clk;
	logic rstnn;
	logic tick_1us;
	logic ext_irq;
	logic allows_holds;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	lock_vec_t lock_status;
	apb_req_t ext_req;
	apb_rsp_t ext_rsp;
	logic delay_notice;
	data_t core_irq_vector;

	integer seed = 32'h9019_bde5;
	int err_count = 0;
	int xfer_count = 0;
	int notice_count = 0;
	data_t rd_data;
	logic rd_err;
	data_t snap_count;
	logic snap_pending;

	// Reference model state
	logic m_en;
	logic m_irq_en;
	data_t m_compare;
	data_t m_count;
	logic m_pending;
	logic m_delay_run;
	data_t m_delay_left;
	logic m_notice;
	logic tmr_wr;
	reg_ofs_t ofs;
	data_t exp_vec;
	data_t model_mem [16];
	data_t ext_mem [16];
	logic [3:0] c_idx;
	logic c_write;
	int c_waits;

	data_t wd;
	data_t exp_data;
	addr_t addr;
	lock_vec_t mask;
	lock_vec_t hold_lock;
	int n;
	int prev;
	int wait_cycles;
	logic hold_done;
	logic [3:0] idx;

	core_peri_group i_dut (
		.clk(clk),
		.rstnn(rstnn),
		.tick_1us(tick_1us),
		.ext_irq(ext_irq),
		.allows_holds(allows_holds),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.lock_status(lock_status),
		.ext_req(ext_req),
		.ext_rsp(ext_rsp),
		.delay_notice(delay_notice),
		.core_irq_vector(core_irq_vector)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD/2) clk = ~clk;
	end

	initial
	begin
		#(NUM_XFER * XFER_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	task automatic log_mismatch(input string name, input data_t exp, input data_t act);
		$display("error %s: expected %h, actual %h", name, exp, act);
		err_count++;
	endtask

	// One APB transfer that samples the response and a model snapshot mid low phase
	task automatic apb_xfer(input addr_t a, input logic write, input data_t data);
		@(negedge clk);
		apb_req.sel = 1'b1;
		apb_req.enable = 1'b0;
		apb_req.addr = a;
		apb_req.write = write;
		apb_req.wdata = data;
		@(negedge clk);
		apb_req.enable = 1'b1;
		#(CLK_PERIOD/4);
		while (!apb_rsp.ready)
		begin
			@(negedge clk);
			#(CLK_PERIOD/4);
		end
		rd_data = apb_rsp.rdata;
		rd_err = apb_rsp.slverr;
		snap_count = m_count;
		snap_pending = m_pending;
		xfer_count++;
		@(negedge clk);
		apb_req.sel = 1'b0;
		apb_req.enable = 1'b0;
	endtask

	// **********************************************************************
	// Reference model updated from the DUT inputs at each rising edge
	// **********************************************************************
	always @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			m_en = 1'b0;
			m_irq_en = 1'b0;
			m_compare = '0;
			m_count = '0;
			m_pending = 1'b0;
			m_delay_run = 1'b0;
			m_delay_left = '0;
			m_notice = 1'b0;
		end
		else
		begin
			tmr_wr = apb_req.sel && apb_req.enable && apb_req.write
				&& (apb_req.addr[SLOT_SEL_HI:SLOT_SEL_LO] == SLOT_TIMER);
			ofs = apb_req.addr[SLOT_SEL_LO-1:0];
			m_notice = 1'b0;
			// Compare uses the count before this tick
			if (tick_1us && m_en && (m_count == m_compare))
				m_pending = 1'b1;
			else if (tmr_wr && (ofs == REG_PENDING) && apb_req.wdata[0])
				m_pending = 1'b0;
			if (tmr_wr && (ofs == REG_COUNT))
				m_count = '0;
			else if (tick_1us && m_en)
				m_count = m_count + 1;
			if (tmr_wr && (ofs == REG_DELAY) && (apb_req.wdata != '0))
			begin
				m_delay_run = 1'b1;
				m_delay_left = apb_req.wdata;
			end
			else if (m_delay_run && tick_1us)
			begin
				if (m_delay_left == 1)
				begin
					m_delay_run = 1'b0;
					m_notice = 1'b1;
				end
				m_delay_left = m_delay_left - 1;
			end
			if (tmr_wr && (ofs == REG_CTRL))
			begin
				m_en = apb_req.wdata[CTRL_EN_BIT];
				m_irq_en = apb_req.wdata[CTRL_IRQ_EN_BIT];
			end
			if (tmr_wr && (ofs == REG_COMPARE))
				m_compare = apb_req.wdata;
		end
	end

	// Per-cycle checks of the interrupt vector and the delay notice
	initial
	begin
		forever
		begin
			@(posedge clk);
			#(CLK_PERIOD/4);
			if (rstnn)
			begin
				exp_vec = '0;
				exp_vec[IRQ_TIMER_BIT] = m_pending && m_irq_en;
				exp_vec[IRQ_EXT_BIT] = ext_irq;
				if (core_irq_vector !== exp_vec)
					log_mismatch("irq vector", exp_vec, core_irq_vector);
				if (delay_notice !== m_notice)
					log_mismatch("delay notice", data_t'(m_notice), data_t'(delay_notice));
				if (delay_notice)
					notice_count++;
			end
		end
	end

	// Random single-cycle ticks and ext_irq changes
	initial
	begin
		forever
		begin
			@(negedge clk);
			tick_1us = (($random(seed) & 7) == 0) && !tick_1us;
			if (($random(seed) & 15) == 0)
				ext_irq = !ext_irq;
		end
	end

	// External completer with 0 to 3 wait cycles
	initial
	begin
		forever
		begin
			@(posedge clk);
			if (ext_req.sel && !ext_req.enable)
			begin
				c_idx = ext_req.addr[5:2];
				c_write = ext_req.write;
				c_waits = $random(seed) & 3;
				@(negedge clk);
				repeat (c_waits) @(negedge clk);
				ext_rsp.ready = 1'b1;
				ext_rsp.rdata = c_write ? '0 : ext_mem[c_idx];
				@(posedge clk);
				if (c_write)
					ext_mem[c_idx] = ext_req.wdata;
				@(negedge clk);
				ext_rsp.ready = 1'b0;
			end
		end
	end

	// **********************************************************************
	// Test sequence
	// **********************************************************************
	initial
	begin
		rstnn = 1'b0;
		tick_1us = 1'b0;
		ext_irq = 1'b0;
		allows_holds = 1'b0;
		apb_req = '0;
		lock_status = '0;
		ext_rsp = '0;
		for (int i = 0; i < 16; i++)
		begin
			ext_mem[i] = 32'hc0de_0000 ^ (i * 32'h0101_0004);
			model_mem[i] = ext_mem[i];
		end
		repeat (16) @(negedge clk);
		rstnn = 1'b1;

		// Timer register readback and unknown offsets
		repeat (20)
		begin
			wd = $random(seed);
			apb_xfer(addr_t'(REG_CTRL), 1'b1, wd);
			apb_xfer(addr_t'(REG_CTRL), 1'b0, '0);
			if (rd_data !== (wd & 32'h3))
				log_mismatch("ctrl readback", wd & 32'h3, rd_data);
			wd = $random(seed);
			apb_xfer(addr_t'(REG_COMPARE), 1'b1, wd);
			apb_xfer(addr_t'(REG_COMPARE), 1'b0, '0);
			if (rd_data !== wd)
				log_mismatch("compare readback", wd, rd_data);
			addr = 32'h800 | ($random(seed) & 32'h7fc);
			apb_xfer(addr, 1'b0, '0);
			if (rd_err !== 1'b1)
				log_mismatch("timer unknown offset", 1, data_t'(rd_err));
		end

		// Counting, compare match and pending clear
		apb_xfer(addr_t'(REG_CTRL), 1'b1, 32'h3);
		apb_xfer(addr_t'(REG_COMPARE), 1'b1, $random(seed) & 15);
		apb_xfer(addr_t'(REG_COUNT), 1'b1, '0);
		apb_xfer(addr_t'(REG_PENDING), 1'b1, 32'h1);
		repeat (30)
		begin
			repeat ($random(seed) & 7) @(negedge clk);
			apb_xfer(addr_t'(REG_COUNT), 1'b0, '0);
			if (rd_data !== snap_count)
				log_mismatch("count read", snap_count, rd_data);
			apb_xfer(addr_t'(REG_PENDING), 1'b0, '0);
			if (rd_data !== data_t'(snap_pending))
				log_mismatch("pending read", data_t'(snap_pending), rd_data);
			if (snap_pending)
			begin
				apb_xfer(addr_t'(REG_PENDING), 1'b1, 32'h1);
				apb_xfer(addr_t'(REG_COUNT), 1'b1, '0);
				apb_xfer(addr_t'(REG_COMPARE), 1'b1, $random(seed) & 15);
				apb_xfer(addr_t'(REG_CTRL), 1'b1, 32'h1 | ($random(seed) & 2));
			end
		end

		// One-shot delay
		repeat (3)
		begin
			n = 1 + ($random(seed) & 7);
			prev = notice_count;
			apb_xfer(addr_t'(REG_DELAY), 1'b1, n);
			wait_cycles = 0;
			while ((notice_count == prev) && (wait_cycles < 400))
			begin
				@(negedge clk);
				wait_cycles++;
			end
			if (notice_count == prev)
			begin
				$display("error: no delay_notice within 400 cycles of a %0d tick delay", n);
				err_count++;
			end
			repeat (2) @(negedge clk);
			if (notice_count !== prev + 1)
				log_mismatch("delay pulse count", prev + 1, notice_count);
		end

		// Lock queries with levels stable well past the synchronizer
		repeat (10)
		begin
			@(negedge clk);
			lock_status = $random(seed);
			repeat (3) @(negedge clk);
			mask = $random(seed);
			addr = '0;
			addr[SLOT_SEL_HI:SLOT_SEL_LO] = SLOT_LOCK;
			addr[LOCK_MASK_LO +: NUM_LOCK] = mask;
			apb_xfer(addr, 1'b0, '0);
			exp_data = data_t'(|(mask & lock_status));
			if (rd_data !== exp_data)
				log_mismatch("lock query", exp_data, rd_data);
			if (rd_err !== 1'b0)
				log_mismatch("lock slverr", 0, data_t'(rd_err));
		end

		// Hold while a masked lock is busy
		@(negedge clk);
		allows_holds = 1'b1;
		hold_lock = lock_vec_t'(1) << ($random(seed) & 7);
		lock_status = hold_lock;
		repeat (4) @(negedge clk);
		addr = '0;
		addr[SLOT_SEL_HI:SLOT_SEL_LO] = SLOT_LOCK;
		addr[LOCK_MASK_LO +: NUM_LOCK] = hold_lock;
		hold_done = 1'b0;
		fork
			begin
				apb_xfer(addr, 1'b0, '0);
				hold_done = 1'b1;
			end
			begin
				repeat (4 + ($random(seed) & 3)) @(negedge clk);
				if (hold_done)
				begin
					$display("error: lock access completed while the lock was busy");
					err_count++;
				end
				lock_status = '0;
			end
		join
		if (rd_data !== '0)
			log_mismatch("lock hold release", 0, rd_data);
		allows_holds = 1'b0;

		// External slot and unmapped slot with random upper address bits
		repeat (40)
		begin
			idx = $random(seed);
			addr = $random(seed);
			addr[SLOT_SEL_HI:SLOT_SEL_LO] = SLOT_EXT;
			addr[5:2] = idx;
			addr[1:0] = 2'b00;
			if ($random(seed) & 1)
			begin
				wd = $random(seed);
				apb_xfer(addr, 1'b1, wd);
				model_mem[idx] = wd;
			end
			else
			begin
				apb_xfer(addr, 1'b0, '0);
				if (rd_data !== model_mem[idx])
					log_mismatch("ext read", model_mem[idx], rd_data);
			end
			if (rd_err !== 1'b0)
				log_mismatch("ext slverr", 0, data_t'(rd_err));
		end
		repeat (10)
		begin
			addr = $random(seed);
			addr[SLOT_SEL_HI:SLOT_SEL_LO] = SLOT_NONE;
			apb_xfer(addr, $random(seed) & 1, $random(seed));
			if ((rd_err !== 1'b1) || (rd_data !== '0))
				log_mismatch("unmapped slot", 32'h1, {rd_data[BW_DATA-1:1], rd_err});
		end

		repeat (4) @(negedge clk);
		$display("%0d transfers, %0d errors", xfer_count, err_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* flist.f */
verilog/core_peri_pkg.sv
verilog/timer_reg_pkg.sv
verilog/apb_slot_decoder.sv
verilog/timer_regs.sv
verilog/timer_core.sv
verilog/lock_status_port.sv
verilog/core_peri_group.sv
dv/tb_core_peri_group.sv

/* verilog/apb_slot_decoder.sv */
// Combinational APB slot decoder; unmapped slot answers with slverr and zero rdata
// Requires the requester to hold addr stable during an access
`timescale 1ns/1ns

module apb_slot_decoder
	import core_peri_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input apb_req_t up_req,
	output apb_rsp_t up_rsp,
	output apb_req_t slot_req [NUM_SLOT],
	input apb_rsp_t slot_rsp [NUM_SLOT]
);

	slot_idx_t slot_idx;

	assign slot_idx = up_req.addr[SLOT_SEL_HI:SLOT_SEL_LO];

	// **********************************************************************
	// Request fan-out
	// **********************************************************************
	always_comb
	begin
		for (int i = 0; i < NUM_SLOT; i++)
		begin
			slot_req[i] = up_req;
			// Only the addressed slot sees sel
			slot_req[i].sel = up_req.sel && (slot_idx == slot_idx_t'(i));
		end
	end

	// **********************************************************************
	// Response mux
	// **********************************************************************
	always_comb
	begin
		if (slot_idx == SLOT_NONE)
		begin
			// Nothing lives here, finish at once with an error
			up_rsp.rdata = '0;
			up_rsp.ready = 1'b1;
			up_rsp.slverr = 1'b1;
		end
		else
		begin
			up_rsp = slot_rsp[slot_idx];
		end
	end

	// A stalled transfer must keep its address, else the slot choice would move
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!rstnn)
		(up_req.sel && !up_rsp.ready) |=> $stable(up_req.addr)
	)
	else
		$error("addr changed while the transfer was stalled");

endmodule

/* verilog/core_peri_group.sv */
// Core peripheral group behind one APB port: timer, lock port, external slot
// Single clock domain; only lock_status and tick_1us come from outside logic
`timescale 1ns/1ns

module core_peri_group
	import core_peri_pkg::*, timer_reg_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic tick_1us,
	input logic ext_irq,
	input logic allows_holds,
	input apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input lock_vec_t lock_status,
	output apb_req_t ext_req,
	input apb_rsp_t ext_rsp,
	output logic delay_notice,
	output data_t core_irq_vector
);

	apb_req_t slot_req [NUM_SLOT];
	apb_rsp_t slot_rsp [NUM_SLOT];
	timer_cfg_t timer_cfg;
	timer_stat_t timer_stat;
	logic timer_irq;

	apb_slot_decoder i_decoder (
		.clk(clk),
		.rstnn(rstnn),
		.up_req(apb_req),
		.up_rsp(apb_rsp),
		.slot_req(slot_req),
		.slot_rsp(slot_rsp)
	);

	// **********************************************************************
	// Timer
	// **********************************************************************
	timer_regs i_timer_regs (
		.clk(clk),
		.rstnn(rstnn),
		.req(slot_req[SLOT_TIMER]),
		.rsp(slot_rsp[SLOT_TIMER]),
		.cfg(timer_cfg),
		.stat(timer_stat)
	);

	timer_core i_timer_core (
		.clk(clk),
		.rstnn(rstnn),
		.tick_1us(tick_1us),
		.cfg(timer_cfg),
		.stat(timer_stat),
		.timer_irq(timer_irq),
		.delay_notice(delay_notice)
	);

	lock_status_port i_lock_port (
		.clk(clk),
		.rstnn(rstnn),
		.allows_holds(allows_holds),
		.lock_async(lock_status),
		.req(slot_req[SLOT_LOCK]),
		.rsp(slot_rsp[SLOT_LOCK])
	);

	// External completer, stands in for the cache-control unit
	assign ext_req = slot_req[SLOT_EXT];
	assign slot_rsp[SLOT_EXT] = ext_rsp;

	// Unmapped slot has no completer, the decoder answers for it
	assign slot_rsp[SLOT_NONE] = '0;

	always_comb
	begin
		core_irq_vector = '0;
		core_irq_vector[IRQ_TIMER_BIT] = timer_irq;
		core_irq_vector[IRQ_EXT_BIT] = ext_irq;
	end

endmodule

/* verilog/core_peri_pkg.sv */
// Bus widths, APB structs, slot map and interrupt positions of the core peripheral group
// The slot map is fixed; address bits above the slot field are ignored
package core_peri_pkg;

	// **********************************************************************
	// Bus widths
	// **********************************************************************
	localparam int BW_ADDR = 32;
	localparam int BW_DATA = 32;

	typedef logic [BW_ADDR-1:0] addr_t;
	typedef logic [BW_DATA-1:0] data_t;

	// Requester side of an APB port
	typedef struct packed {
		logic sel;
		logic enable;
		addr_t addr;
		logic write;
		data_t wdata;
	} apb_req_t;

	// Completer side of an APB port
	typedef struct packed {
		data_t rdata;
		logic ready;
		logic slverr;
	} apb_rsp_t;

	// **********************************************************************
	// Slot map
	// **********************************************************************
	localparam int NUM_SLOT = 4;
	localparam int SLOT_SEL_HI = 13;
	localparam int SLOT_SEL_LO = 12;

	typedef logic [SLOT_SEL_HI-SLOT_SEL_LO:0] slot_idx_t;

	localparam slot_idx_t SLOT_TIMER = 2'd0;
	localparam slot_idx_t SLOT_LOCK = 2'd1;
	localparam slot_idx_t SLOT_EXT = 2'd2;
	localparam slot_idx_t SLOT_NONE = 2'd3;

	// Lock port, the query mask sits in the word-address bits
	localparam int NUM_LOCK = 8;
	localparam int LOCK_MASK_LO = 2;
	typedef logic [NUM_LOCK-1:0] lock_vec_t;

	// Positions in the core interrupt vector
	localparam int IRQ_TIMER_BIT = 7;
	localparam int IRQ_EXT_BIT = 11;

endpackage

/* verilog/lock_status_port.sv */
// Lock status port, query mask in addr bits 9:2, read returns 1 if a masked lock is busy
// Lock levels see a two-flop delay; with allows_holds the access waits for release
`timescale 1ns/1ns

module lock_status_port
	import core_peri_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic allows_holds,
	input lock_vec_t lock_async,
	input apb_req_t req,
	output apb_rsp_t rsp
);

	lock_vec_t lock_meta;
	lock_vec_t lock_sync;
	lock_vec_t lock_mask;
	logic busy;

	// Two-flop synchronizer
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			lock_meta <= '0;
			lock_sync <= '0;
		end
		else
		begin
			lock_meta <= lock_async;
			lock_sync <= lock_meta;
		end
	end

	assign lock_mask = req.addr[LOCK_MASK_LO +: NUM_LOCK];
	assign busy = |(lock_mask & lock_sync);

	// Writes complete like reads and change nothing
	always_comb
	begin
		rsp.rdata = '0;
		rsp.rdata[0] = busy;
		rsp.ready = !(allows_holds && req.sel && busy);
		rsp.slverr = 1'b0;
	end

endmodule

/* verilog/timer_core.sv */
// Microsecond counter with compare interrupt and one-shot delay countdown
// tick_1us must be a single-cycle pulse in the clk domain
`timescale 1ns/1ns

module timer_core
	import core_peri_pkg::*, timer_reg_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input logic tick_1us,
	input timer_cfg_t cfg,
	output timer_stat_t stat,
	output logic timer_irq,
	output logic delay_notice
);

	data_t count_q;
	logic pending_q;
	delay_state_e delay_state;
	data_t delay_left;
	logic count_tick;

	assign count_tick = tick_1us && cfg.enable;

	// **********************************************************************
	// Counter and compare
	// **********************************************************************
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			count_q <= '0;
			pending_q <= 1'b0;
		end
		else
		begin
			if (cfg.count_clear)
				count_q <= '0;
			else if (count_tick)
				count_q <= count_q + 1'b1;
			// New match wins over a clear in the same cycle
			if (count_tick && (count_q == cfg.compare))
				pending_q <= 1'b1;
			else if (cfg.pending_clear)
				pending_q <= 1'b0;
		end
	end

	// **********************************************************************
	// Delay countdown
	// **********************************************************************
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			delay_state <= DELAY_IDLE;
			delay_left <= '0;
			delay_notice <= 1'b0;
		end
		else
		begin
			delay_notice <= 1'b0;
			// A reload restarts the countdown and ignores the tick of the load cycle
			if (cfg.delay_load)
			begin
				delay_state <= DELAY_RUN;
				delay_left <= cfg.delay_value;
			end
			else if ((delay_state == DELAY_RUN) && tick_1us)
			begin
				if (delay_left == data_t'(1))
				begin
					delay_state <= DELAY_IDLE;
					delay_notice <= 1'b1;
				end
				delay_left <= delay_left - 1'b1;
			end
		end
	end

	assign stat.count = count_q;
	assign stat.pending = pending_q;
	assign stat.delay_busy = (delay_state == DELAY_RUN);
	assign timer_irq = pending_q && cfg.irq_en;

	// A tick held high would count one microsecond twice
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rstnn)
		tick_1us |=> !tick_1us
	)
	else
		$error("tick_1us held for more than one cycle");

endmodule

/* verilog/timer_reg_pkg.sv */
// Register map and shared types of the microsecond timer
package timer_reg_pkg;

	// Offset within the timer slot
	typedef logic [core_peri_pkg::SLOT_SEL_LO-1:0] reg_ofs_t;

	localparam reg_ofs_t REG_CTRL = 'h000;
	localparam reg_ofs_t REG_COUNT = 'h004;
	localparam reg_ofs_t REG_COMPARE = 'h008;
	localparam reg_ofs_t REG_PENDING = 'h00C;
	localparam reg_ofs_t REG_DELAY = 'h010;

	// CTRL fields
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_IRQ_EN_BIT = 1;

	typedef enum logic {
		DELAY_IDLE,
		DELAY_RUN
	} delay_state_e;

	// Strobes are single-cycle and come straight from the access cycle
	typedef struct packed {
		logic enable;
		logic irq_en;
		core_peri_pkg::data_t compare;
		logic count_clear;
		logic pending_clear;
		logic delay_load;
		core_peri_pkg::data_t delay_value;
	} timer_cfg_t;

	typedef struct packed {
		core_peri_pkg::data_t count;
		logic pending;
		logic delay_busy;
	} timer_stat_t;

endpackage

/* verilog/timer_regs.sv */
// Timer register block, always ready; unknown offsets answer slverr
// COUNT write clears the count, PENDING bit 0 is write-1-to-clear
`timescale 1ns/1ns

module timer_regs
	import core_peri_pkg::*, timer_reg_pkg::*;
(
	input logic clk,
	input logic rstnn,
	input apb_req_t req,
	output apb_rsp_t rsp,
	output timer_cfg_t cfg,
	input timer_stat_t stat
);

	reg_ofs_t ofs;
	logic wr;
	logic ctrl_en;
	logic ctrl_irq_en;
	data_t compare_q;

	assign ofs = req.addr[$bits(reg_ofs_t)-1:0];
	// Ready is constant, so every access cycle is the last one
	assign wr = req.sel && req.enable && req.write;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			ctrl_en <= 1'b0;
			ctrl_irq_en <= 1'b0;
			compare_q <= '0;
		end
		else if (wr)
		begin
			if (ofs == REG_CTRL)
			begin
				ctrl_en <= req.wdata[CTRL_EN_BIT];
				ctrl_irq_en <= req.wdata[CTRL_IRQ_EN_BIT];
			end
			if (ofs == REG_COMPARE)
				compare_q <= req.wdata;
		end
	end

	always_comb
	begin
		cfg.enable = ctrl_en;
		cfg.irq_en = ctrl_irq_en;
		cfg.compare = compare_q;
		cfg.count_clear = wr && (ofs == REG_COUNT);
		cfg.pending_clear = wr && (ofs == REG_PENDING) && req.wdata[0];
		// A zero delay starts nothing
		cfg.delay_load = wr && (ofs == REG_DELAY) && (req.wdata != '0);
		cfg.delay_value = req.wdata;
	end

	// Read mux
	always_comb
	begin
		rsp.rdata = '0;
		rsp.ready = 1'b1;
		rsp.slverr = 1'b0;
		case (ofs)
			REG_CTRL:
			begin
				rsp.rdata[CTRL_EN_BIT] = ctrl_en;
				rsp.rdata[CTRL_IRQ_EN_BIT] = ctrl_irq_en;
			end
			REG_COUNT: rsp.rdata = stat.count;
			REG_COMPARE: rsp.rdata = compare_q;
			REG_PENDING: rsp.rdata[0] = stat.pending;
			REG_DELAY: rsp.rdata[0] = stat.delay_busy;
			default: rsp.slverr = 1'b1;
		endcase
	end

endmodule
